// ==== flist.f ====
rtl/dcache_pkg.sv
rtl/dcache_ctrl.sv
rtl/dcache_ways.sv
rtl/dcache_lru.sv
rtl/dcache_evict.sv
rtl/dcache_top.sv
testbench/tb_dcache.sv

// ==== rtl/dcache_ctrl.sv ====
`timescale 1ns/1ns

module dcache_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic req_valid,
  input  logic req_we,
  input  logic hit,
  input  logic victim_dirty,
  input  logic mem_rd_req_ready,
  input  logic mem_rd_rsp_valid,
  input  logic mem_rd_rsp_last,
  input  logic mem_wr_req_ready,
  input  logic mem_wr_data_ready,
  input  logic rsp_ready,
  input  logic wb_last,
  output logic req_ready,
  output logic rsp_valid,
  output logic mem_rd_req_valid,
  output logic mem_rd_rsp_ready,
  output logic mem_wr_req_valid,
  output logic mem_wr_data_valid,
  output logic hit_write,
  output logic refill_beat,
  output logic lru_touch,
  output logic evict_load,
  output logic evict_shift,
  output logic fill_sel
);

  dcache_pkg::ctrl_state_e state_q;
  dcache_pkg::ctrl_state_e state_d;

  logic miss;      // new request that does not hit
  logic fill_done; // last refill beat accepted

  assign miss      = req_valid && !hit;
  assign fill_done = mem_rd_rsp_valid && mem_rd_rsp_last;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= dcache_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q; // stay put unless a handshake completes
    case (state_q)
      dcache_pkg::IDLE: begin
        if (req_valid && hit) begin
          state_d = req_we ? dcache_pkg::WR_HIT : dcache_pkg::RD_HIT;
        end else if (miss) begin
          // a dirty victim has to leave before the refill can start
          state_d = victim_dirty ? dcache_pkg::WB_REQ : dcache_pkg::FILL_REQ;
        end
      end
      dcache_pkg::RD_HIT:  state_d = dcache_pkg::RESP;
      dcache_pkg::WR_HIT:  state_d = dcache_pkg::IDLE; // writes are not answered
      dcache_pkg::RESP: begin
        if (rsp_ready) state_d = dcache_pkg::IDLE;
      end
      dcache_pkg::WB_REQ: begin
        if (mem_wr_req_ready) state_d = dcache_pkg::WB_DATA;
      end
      dcache_pkg::WB_DATA: begin
        if (mem_wr_data_ready && wb_last) state_d = dcache_pkg::FILL_REQ;
      end
      dcache_pkg::FILL_REQ: begin
        if (mem_rd_req_ready) state_d = dcache_pkg::FILL_DATA;
      end
      dcache_pkg::FILL_DATA: begin
        // line is complete so the request replays as a hit
        if (fill_done) state_d = req_we ? dcache_pkg::WR_HIT : dcache_pkg::RD_HIT;
      end
      default: state_d = dcache_pkg::IDLE;
    endcase
  end

  // cpu handshakes
  assign req_ready = (state_q == dcache_pkg::RD_HIT) || (state_q == dcache_pkg::WR_HIT);
  assign rsp_valid = (state_q == dcache_pkg::RESP);

  // memory handshakes held while the far side stalls
  assign mem_rd_req_valid  = (state_q == dcache_pkg::FILL_REQ);
  assign mem_rd_rsp_ready  = (state_q == dcache_pkg::FILL_DATA);
  assign mem_wr_req_valid  = (state_q == dcache_pkg::WB_REQ);
  assign mem_wr_data_valid = (state_q == dcache_pkg::WB_DATA);

  // datapath strobes
  assign hit_write   = (state_q == dcache_pkg::WR_HIT);
  assign refill_beat = (state_q == dcache_pkg::FILL_DATA) && mem_rd_rsp_valid;
  assign lru_touch   = req_ready; // every access ends in one of the hit states
  assign evict_load  = (state_q == dcache_pkg::IDLE) && miss && victim_dirty;
  assign evict_shift = (state_q == dcache_pkg::WB_DATA) && mem_wr_data_ready;
  assign fill_sel    = (state_q == dcache_pkg::FILL_REQ) || (state_q == dcache_pkg::FILL_DATA);

  // the cpu only ever sees req_ready from the two hit states
  a_req_ready_in_hit : assert property (@(posedge clk) disable iff (rst)
    req_ready |-> (state_q inside {dcache_pkg::RD_HIT, dcache_pkg::WR_HIT}));

  // write-back and refill requests are strictly sequential
  a_one_mem_req : assert property (@(posedge clk) disable iff (rst)
    !(mem_rd_req_valid && mem_wr_req_valid));

  // a request is only taken once its line is resident, refilled or not
  a_hit_when_taken : assert property (@(posedge clk) disable iff (rst)
    req_ready |-> hit);

endmodule

// ==== rtl/dcache_evict.sv ====
`timescale 1ns/1ns

module dcache_evict #(
  parameter int num_ways = 6
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              evict_load,
  input  logic              evict_shift,
  input  dcache_pkg::line_t victim_line,
  output dcache_pkg::word_t wb_word,
  output logic              wb_last
);

  dcache_pkg::line_t line_q;   // snapshot of the dirty victim
  logic [2:0]        beat_q;   // beats already sent

  // the way number width only covers 2 to 8 ways
  if (num_ways < 2 || num_ways > 8) begin : g_ways_range
    $error("dcache_evict: num_ways must be within 2 to 8");
  end

  always_ff @(posedge clk) begin
    if (evict_load) begin
      line_q <= victim_line;
    end else if (evict_shift) begin
      line_q <= line_q >> dcache_pkg::word_w; // next word drops into the low slot
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      beat_q <= '0;
    end else if (evict_load) begin
      beat_q <= '0;
    end else if (evict_shift) begin
      beat_q <= beat_q + 1'b1; // wraps back to 0 after beat 8
    end
  end

  assign wb_word = line_q[dcache_pkg::word_w-1:0]; // word 0 goes out first
  assign wb_last = (beat_q == 3'(dcache_pkg::words_per_line - 1));

endmodule

// ==== rtl/dcache_lru.sv ====
`timescale 1ns/1ns

module dcache_lru #(
  parameter int num_sets = 8,
  parameter int num_ways = 6
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [dcache_pkg::index_w-1:0]   index,
  input  logic                             lru_touch,
  input  logic [dcache_pkg::way_idx_w-1:0] hit_way,
  output logic [dcache_pkg::way_idx_w-1:0] victim_way
);

  logic [dcache_pkg::stamp_w-1:0] stamp_cnt_q;                  // global access clock
  logic [dcache_pkg::stamp_w-1:0] stamp_q [num_sets][num_ways]; // last-hit time per way
  logic [dcache_pkg::stamp_w-1:0] oldest;

  always_ff @(posedge clk) begin
    if (rst) begin
      stamp_cnt_q <= 1; // starts above the cleared stamps so a touched way is never oldest
      for (int s = 0; s < num_sets; s++) begin
        for (int w = 0; w < num_ways; w++) begin
          stamp_q[s][w] <= '0;
        end
      end
    end else if (lru_touch) begin
      stamp_q[index][hit_way] <= stamp_cnt_q;
      stamp_cnt_q             <= stamp_cnt_q + 1'b1; // wraps, no saturation
    end
  end

  // smallest stamp in the set, strict compare keeps ties on the lower way
  always_comb begin
    oldest     = stamp_q[index][0];
    victim_way = '0;
    for (int w = 1; w < num_ways; w++) begin
      if (stamp_q[index][w] < oldest) begin
        oldest     = stamp_q[index][w];
        victim_way = w[dcache_pkg::way_idx_w-1:0];
      end
    end
  end

  a_victim_range : assert property (@(posedge clk) disable iff (rst)
    victim_way < num_ways);

endmodule

// ==== rtl/dcache_pkg.sv ====
package dcache_pkg;

  // geometry shared by every block of the cache
  localparam int word_w         = 32;
  localparam int offset_w       = 5;   // byte offset inside a 32-byte line
  localparam int index_w        = 3;
  localparam int tag_w          = 24;
  localparam int words_per_line = 8;   // one burst moves a whole line
  localparam int line_w         = 256;
  localparam int way_idx_w      = 3;   // enough for up to 8 ways
  localparam int stamp_w        = 32;

  typedef logic [word_w-1:0] word_t;
  typedef logic [tag_w-1:0]  tag_t;
  typedef logic [line_w-1:0] line_t;

  // cpu address split into its cache fields, msb first
  typedef struct packed {
    tag_t               tag;
    logic [index_w-1:0] index;
    logic [2:0]         word_idx;  // word within the line
    logic [1:0]         byte_off;  // ignored, accesses are word aligned
  } addr_t;

  // one cpu request, 69 bits
  typedef struct packed {
    logic       we;     // 1 write, 0 read
    addr_t      addr;
    word_t      wdata;
    logic [3:0] wstrb;  // byte enables for writes
  } cpu_req_t;

  typedef enum logic [2:0] {
    IDLE,
    RD_HIT,
    WR_HIT,
    RESP,
    WB_REQ,
    WB_DATA,
    FILL_REQ,
    FILL_DATA
  } ctrl_state_e;

endpackage

// ==== rtl/dcache_top.sv ====
`timescale 1ns/1ns

module dcache_top #(
  parameter int num_sets = 8,
  parameter int num_ways = 6
) (
  input  logic                 clk,
  input  logic                 rst,
  // cpu request and read response
  input  logic                 req_valid,
  input  dcache_pkg::cpu_req_t req,
  output logic                 req_ready,
  output logic                 rsp_valid,
  output dcache_pkg::word_t    rsp_data,
  input  logic                 rsp_ready,
  // refill burst
  output logic                 mem_rd_req_valid,
  output logic [31:0]          mem_rd_req_addr,
  input  logic                 mem_rd_req_ready,
  input  logic                 mem_rd_rsp_valid,
  input  dcache_pkg::word_t    mem_rd_rsp_data,
  input  logic                 mem_rd_rsp_last,
  output logic                 mem_rd_rsp_ready,
  // write-back burst
  output logic                 mem_wr_req_valid,
  output logic [31:0]          mem_wr_req_addr,
  input  logic                 mem_wr_req_ready,
  output logic                 mem_wr_data_valid,
  output dcache_pkg::word_t    mem_wr_data,
  output logic                 mem_wr_data_last,
  input  logic                 mem_wr_data_ready
);

  logic                             hit;
  logic [dcache_pkg::way_idx_w-1:0] hit_way;
  logic [dcache_pkg::way_idx_w-1:0] victim_way;
  logic                             victim_dirty;
  dcache_pkg::tag_t                 victim_tag;
  dcache_pkg::line_t                victim_line;
  logic                             hit_write;
  logic                             refill_beat;
  logic                             lru_touch;
  logic                             evict_load;
  logic                             evict_shift;
  logic                             wb_last;
  logic                             fill_sel;
  logic [31:0]                      mem_addr; // shared by both request channels

  // line aligned, either the requested line or the victim going out
  assign mem_addr = fill_sel ?
    {req.addr.tag, req.addr.index, {dcache_pkg::offset_w{1'b0}}} :
    {victim_tag,   req.addr.index, {dcache_pkg::offset_w{1'b0}}};

  assign mem_rd_req_addr  = mem_addr;
  assign mem_wr_req_addr  = mem_addr;
  assign mem_wr_data_last = wb_last;

  dcache_ctrl u_ctrl (
    .clk               (clk),
    .rst               (rst),
    .req_valid         (req_valid),
    .req_we            (req.we),
    .hit               (hit),
    .victim_dirty      (victim_dirty),
    .mem_rd_req_ready  (mem_rd_req_ready),
    .mem_rd_rsp_valid  (mem_rd_rsp_valid),
    .mem_rd_rsp_last   (mem_rd_rsp_last),
    .mem_wr_req_ready  (mem_wr_req_ready),
    .mem_wr_data_ready (mem_wr_data_ready),
    .rsp_ready         (rsp_ready),
    .wb_last           (wb_last),
    .req_ready         (req_ready),
    .rsp_valid         (rsp_valid),
    .mem_rd_req_valid  (mem_rd_req_valid),
    .mem_rd_rsp_ready  (mem_rd_rsp_ready),
    .mem_wr_req_valid  (mem_wr_req_valid),
    .mem_wr_data_valid (mem_wr_data_valid),
    .hit_write         (hit_write),
    .refill_beat       (refill_beat),
    .lru_touch         (lru_touch),
    .evict_load        (evict_load),
    .evict_shift       (evict_shift),
    .fill_sel          (fill_sel)
  );

  dcache_ways #(
    .num_sets (num_sets),
    .num_ways (num_ways)
  ) u_ways (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .hit_write    (hit_write),
    .refill_beat  (refill_beat),
    .fill_word    (mem_rd_rsp_data),
    .victim_way   (victim_way),
    .hit          (hit),
    .hit_way      (hit_way),
    .hit_word     (rsp_data),    // read data comes straight from the hit way
    .victim_line  (victim_line),
    .victim_tag   (victim_tag),
    .victim_dirty (victim_dirty)
  );

  dcache_lru #(
    .num_sets (num_sets),
    .num_ways (num_ways)
  ) u_lru (
    .clk        (clk),
    .rst        (rst),
    .index      (req.addr.index),
    .lru_touch  (lru_touch),
    .hit_way    (hit_way),
    .victim_way (victim_way)
  );

  dcache_evict #(
    .num_ways (num_ways)
  ) u_evict (
    .clk         (clk),
    .rst         (rst),
    .evict_load  (evict_load),
    .evict_shift (evict_shift),
    .victim_line (victim_line),
    .wb_word     (mem_wr_data),
    .wb_last     (wb_last)
  );

endmodule

// ==== rtl/dcache_ways.sv ====
`timescale 1ns/1ns

module dcache_ways #(
  parameter int num_sets = 8,
  parameter int num_ways = 6
) (
  input  logic                                clk,
  input  logic                                rst,
  input  dcache_pkg::cpu_req_t                req,
  input  logic                                hit_write,
  input  logic                                refill_beat,
  input  dcache_pkg::word_t                   fill_word,
  input  logic [dcache_pkg::way_idx_w-1:0]    victim_way,
  output logic                                hit,
  output logic [dcache_pkg::way_idx_w-1:0]    hit_way,
  output dcache_pkg::word_t                   hit_word,
  output dcache_pkg::line_t                   victim_line,
  output dcache_pkg::tag_t                    victim_tag,
  output logic                                victim_dirty
);

  logic [num_ways-1:0] valid_q [num_sets];
  logic [num_ways-1:0] dirty_q [num_sets];
  dcache_pkg::tag_t    tag_q   [num_sets][num_ways];
  dcache_pkg::line_t   data_q  [num_sets][num_ways];

  logic [dcache_pkg::index_w-1:0] idx;
  logic [num_ways-1:0]            way_hit;
  dcache_pkg::word_t              merged_word; // hit word with the write bytes laid over it

  assign idx = req.addr.index;

  // tag compare on every way of the selected set
  always_comb begin
    for (int w = 0; w < num_ways; w++) begin
      way_hit[w] = valid_q[idx][w] && (tag_q[idx][w] == req.addr.tag);
    end
  end

  assign hit = |way_hit;

  always_comb begin
    hit_way = '0;
    for (int w = num_ways - 1; w >= 0; w--) begin
      if (way_hit[w]) hit_way = w[dcache_pkg::way_idx_w-1:0]; // lowest way wins
    end
  end

  assign hit_word = data_q[idx][hit_way][req.addr.word_idx * dcache_pkg::word_w +:
                                         dcache_pkg::word_w];

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      merged_word[8*b +: 8] = req.wstrb[b] ? req.wdata[8*b +: 8] : hit_word[8*b +: 8];
    end
  end

  // victim view for the controller and the write-back path
  assign victim_line  = data_q[idx][victim_way];
  assign victim_tag   = tag_q[idx][victim_way];
  assign victim_dirty = dirty_q[idx][victim_way];

  // line and tag storage, no reset
  always_ff @(posedge clk) begin
    for (int w = 0; w < num_ways; w++) begin
      if (hit_write && way_hit[w]) begin
        data_q[idx][w][req.addr.word_idx * dcache_pkg::word_w +: dcache_pkg::word_w] <=
          merged_word;
      end else if (refill_beat && (victim_way == w)) begin
        // beats arrive word 0 first and shift down from the top
        data_q[idx][w] <= {fill_word, data_q[idx][w][dcache_pkg::line_w-1:dcache_pkg::word_w]};
        tag_q[idx][w]  <= req.addr.tag;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < num_sets; s++) begin
        valid_q[s] <= '0;
        dirty_q[s] <= '0;
      end
    end else if (hit_write && hit) begin
      dirty_q[idx][hit_way] <= 1'b1;
    end else if (refill_beat) begin
      valid_q[idx][victim_way] <= 1'b1; // valid from the first beat, ctrl waits for last
      dirty_q[idx][victim_way] <= 1'b0;
    end
  end

  a_onehot_hit : assert property (@(posedge clk) disable iff (rst) $onehot0(way_hit));

endmodule

// ==== testbench/tb_dcache.sv ====
`timescale 1ns/1ns

module tb_dcache;

  localparam int num_sets   = 8;
  localparam int num_ways   = 6;
  localparam int wait_limit = 500;          // cycles any single wait may take
  localparam logic [31:0] seed = 32'hb2fb9a5e;

  logic                 clk = 1'b0;
  logic                 rst = 1'b1;
  logic                 req_valid;
  dcache_pkg::cpu_req_t req;
  logic                 req_ready;
  logic                 rsp_valid;
  logic [31:0]          rsp_data;
  logic                 rsp_ready;
  logic                 mem_rd_req_valid;
  logic [31:0]          mem_rd_req_addr;
  logic                 mem_rd_req_ready;
  logic                 mem_rd_rsp_valid;
  logic [31:0]          mem_rd_rsp_data;
  logic                 mem_rd_rsp_last;
  logic                 mem_rd_rsp_ready;
  logic                 mem_wr_req_valid;
  logic [31:0]          mem_wr_req_addr;
  logic                 mem_wr_req_ready;
  logic                 mem_wr_data_valid;
  logic [31:0]          mem_wr_data;
  logic                 mem_wr_data_last;
  logic                 mem_wr_data_ready;

  int          cycle_cnt = 0;
  logic        bp_on     = 1'b0;                 // random back-pressure on every ready
  logic        bp_mem    = 1'b0;                 // back-pressure for the cycle that starts
  logic [31:0] stim_seed = seed;
  logic [31:0] mem_seed  = seed ^ 32'h9e3779b9;  // memory side has its own sequence

  logic [31:0] mem_q    [logic [31:0]];  // backing store keyed by byte address
  logic [31:0] shadow_q [logic [31:0]];  // what every word should hold
  logic [31:0] exp_rsp_q [$];
  logic [31:0] exp_rd_q  [$];            // refill line addresses still to come
  logic [31:0] exp_wr_q  [$];            // write-back line addresses still to come

  logic [23:0] lru_tag   [num_sets][num_ways];  // most recent first
  logic        lru_dirty [num_sets][num_ways];
  int          lru_cnt   [num_sets];

  logic        rd_active = 1'b0;  // memory model burst state
  logic [31:0] rd_base   = '0;
  int          rd_beat   = 0;
  logic [31:0] wr_base   = '0;
  int          wr_beat   = 0;
  logic [31:0] wb_addr_seen = '0; // checker view of the write-back burst
  int          wb_beat_seen = 0;
  int          wb_count     = 0;

  always #20 clk = ~clk;

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  dcache_top #(
    .num_sets (num_sets),
    .num_ways (num_ways)
  ) u_dcache_top (
    .clk               (clk),
    .rst               (rst),
    .req_valid         (req_valid),
    .req               (req),
    .req_ready         (req_ready),
    .rsp_valid         (rsp_valid),
    .rsp_data          (rsp_data),
    .rsp_ready         (rsp_ready),
    .mem_rd_req_valid  (mem_rd_req_valid),
    .mem_rd_req_addr   (mem_rd_req_addr),
    .mem_rd_req_ready  (mem_rd_req_ready),
    .mem_rd_rsp_valid  (mem_rd_rsp_valid),
    .mem_rd_rsp_data   (mem_rd_rsp_data),
    .mem_rd_rsp_last   (mem_rd_rsp_last),
    .mem_rd_rsp_ready  (mem_rd_rsp_ready),
    .mem_wr_req_valid  (mem_wr_req_valid),
    .mem_wr_req_addr   (mem_wr_req_addr),
    .mem_wr_req_ready  (mem_wr_req_ready),
    .mem_wr_data_valid (mem_wr_data_valid),
    .mem_wr_data       (mem_wr_data),
    .mem_wr_data_last  (mem_wr_data_last),
    .mem_wr_data_ready (mem_wr_data_ready)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // never-written word as a bijection of the full address
  function automatic logic [31:0] init_word(input logic [31:0] a);
    return (a ^ 32'h6a09e667) * 32'h9e3779b1;
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] a);
    return mem_q.exists(a) ? mem_q[a] : init_word(a);
  endfunction

  function automatic logic [31:0] shadow_word(input logic [31:0] a);
    return shadow_q.exists(a) ? shadow_q[a] : init_word(a);
  endfunction

  // byte lanes with a strobe take the new data
  function automatic logic [31:0] merge_word(input logic [31:0] old_w,
                                             input logic [31:0] new_w,
                                             input logic [3:0]  strb);
    logic [31:0] w;
    w = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) w[8*b +: 8] = new_w[8*b +: 8];
    end
    return w;
  endfunction

  function automatic logic [31:0] make_addr(input int tag, input int set, input int word);
    return {24'(tag), 3'(set), 3'(word), 2'b00};
  endfunction

  // true lru per set that returns 1 on a miss and names the dirty line that has to leave
  function automatic logic lru_access(input logic [31:0] addr, input logic we,
                                      output logic wb, output logic [31:0] wb_addr);
    int          s;
    int          pos;
    logic [23:0] tag;
    logic        dirty;
    logic        miss;
    s       = int'(addr[7:5]);
    tag     = addr[31:8];
    pos     = -1;
    wb      = 1'b0;
    wb_addr = '0;
    for (int i = 0; i < lru_cnt[s]; i++) begin
      if (lru_tag[s][i] == tag) pos = i;
    end
    miss  = (pos < 0);
    dirty = 1'b0;                           // a refilled line starts clean
    if (!miss) begin
      dirty = lru_dirty[s][pos];
    end else if (lru_cnt[s] == num_ways) begin
      pos     = num_ways - 1;               // least recent sits at the back
      wb      = lru_dirty[s][pos];
      wb_addr = {lru_tag[s][pos], addr[7:5], 5'b00000};
    end else begin
      pos = lru_cnt[s];                     // free way still there
      lru_cnt[s]++;
    end
    for (int i = pos; i > 0; i--) begin
      lru_tag[s][i]   = lru_tag[s][i-1];
      lru_dirty[s][i] = lru_dirty[s][i-1];
    end
    lru_tag[s][0]   = tag;
    lru_dirty[s][0] = dirty || we;
    return miss;
  endfunction

  task automatic stop_run();
    $display("TEST FAIL");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic fail_msg(input string msg);
    $display("%s (at %0t ns)", msg, $time);
    stop_run();
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s, expected %h, got %h", $time, what, expected, actual);
      stop_run();
    end
  endtask

  // one cpu access where rsp_lat counts cycles from the first request cycle to rsp_valid
  task automatic cpu_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, output int rsp_lat);
    logic        wb;
    logic [31:0] wb_addr;
    logic [31:0] waddr;
    logic        done;
    int          start;
    int          n;
    waddr   = {addr[31:2], 2'b00};
    rsp_lat = -1;
    if (lru_access(addr, we, wb, wb_addr)) exp_rd_q.push_back({addr[31:5], 5'b00000});
    if (wb) exp_wr_q.push_back(wb_addr);
    if (we) begin
      shadow_q[waddr] = merge_word(shadow_word(waddr), wdata, wstrb);
    end else begin
      exp_rsp_q.push_back(shadow_word(waddr));
    end
    req       = {we, addr, wdata, wstrb};
    req_valid = 1'b1;
    start     = cycle_cnt;
    n         = 0;
    done      = 1'b0;
    while (!done) begin
      @(posedge clk);
      #1;
      n++;
      done = req_ready;
      if (!done && n >= wait_limit) fail_msg("timeout, the cache never took the request");
    end
    // write-back and refill are over by the time the request is taken
    check_value("refill bursts still missing", 0, exp_rd_q.size());
    check_value("write-back bursts still missing", 0, exp_wr_q.size());
    @(posedge clk);
    #1;
    req_valid = 1'b0;  // req stays put since read data is looked up from it
    if (!we) begin
      n    = 0;
      done = 1'b0;
      while (!done) begin
        if (rsp_valid && rsp_lat < 0) rsp_lat = cycle_cnt - start;
        stim_seed = lcg_next(stim_seed);
        rsp_ready = !bp_on || stim_seed[18];
        done      = rsp_valid && rsp_ready;
        n++;
        if (!done && n >= wait_limit) fail_msg("timeout, no read response from the cache");
        @(posedge clk);
        #1;
      end
      rsp_ready = 1'b0;
    end
  endtask

  // memory model as a burst slave driven 1 ns after the edge
  always @(posedge clk) begin
    bp_mem = bp_on;
    if (!rst) begin
      #1;
      mem_seed          = lcg_next(mem_seed);
      mem_rd_req_ready  = !bp_mem || mem_seed[17];
      mem_wr_req_ready  = !bp_mem || mem_seed[19];
      mem_wr_data_ready = !bp_mem || mem_seed[21];
      if (mem_rd_req_valid && mem_rd_req_ready) begin
        rd_base   = mem_rd_req_addr;
        rd_beat   = 0;
        rd_active = 1'b1;
      end
      if (mem_wr_req_valid && mem_wr_req_ready) begin
        wr_base = mem_wr_req_addr;
        wr_beat = 0;
      end
      if (mem_wr_data_valid && mem_wr_data_ready) begin
        mem_q[wr_base + 32'(4 * wr_beat)] = mem_wr_data;
        wr_beat++;
      end
      mem_rd_rsp_valid = rd_active && (!bp_mem || mem_seed[23]);
      mem_rd_rsp_data  = rd_active ? mem_word(rd_base + 32'(4 * rd_beat)) : '0;
      mem_rd_rsp_last  = (rd_beat == 7);
      if (mem_rd_rsp_valid && mem_rd_rsp_ready) begin
        rd_beat++;
        if (rd_beat == 8) rd_active = 1'b0;  // whole line sent
      end
    end
  end

  // checker sampling handshakes mid-cycle when everything has settled
  always @(negedge clk) begin
    if (!rst) begin
      if (rsp_valid && rsp_ready) begin
        if (exp_rsp_q.size() == 0) begin
          fail_msg("read response without a pending read");
        end else begin
          check_value("read data", exp_rsp_q.pop_front(), rsp_data);
        end
      end
      if (mem_rd_req_valid && mem_rd_req_ready) begin
        if (exp_rd_q.size() == 0) begin
          fail_msg("refill burst issued although the line is resident");
        end else begin
          check_value("refill alignment", 0, mem_rd_req_addr[4:0]);
          check_value("refill address", exp_rd_q.pop_front(), mem_rd_req_addr);
        end
      end
      if (mem_wr_req_valid && mem_wr_req_ready) begin
        if (exp_wr_q.size() == 0) begin
          fail_msg("write-back burst issued with no dirty lru victim");
        end else begin
          check_value("write-back alignment", 0, mem_wr_req_addr[4:0]);
          check_value("write-back address", exp_wr_q.pop_front(), mem_wr_req_addr);
          wb_addr_seen = mem_wr_req_addr;
          wb_beat_seen = 0;
          wb_count++;
        end
      end
      if (mem_wr_data_valid && mem_wr_data_ready) begin
        check_value("write-back data", shadow_word(wb_addr_seen + 32'(4 * wb_beat_seen)),
                    mem_wr_data);
        check_value("write-back last", wb_beat_seen == 7, mem_wr_data_last);
        wb_beat_seen++;
      end
    end
  end

  initial begin
    int          lat;
    logic [31:0] r;
    logic [31:0] d;
    req               = '0;
    req_valid         = 1'b0;
    rsp_ready         = 1'b0;
    mem_rd_req_ready  = 1'b0;
    mem_rd_rsp_valid  = 1'b0;
    mem_rd_rsp_data   = '0;
    mem_rd_rsp_last   = 1'b0;
    mem_wr_req_ready  = 1'b0;
    mem_wr_data_ready = 1'b0;
    for (int s = 0; s < num_sets; s++) lru_cnt[s] = 0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    // cold read with one refill and no write-back
    cpu_access(1'b0, make_addr('h100, 0, 3), 32'h0, 4'h0, lat);
    // same line again hits with fixed latency
    cpu_access(1'b0, make_addr('h100, 0, 5), 32'h0, 4'h0, lat);
    check_value("read hit latency", 2, lat);
    // partial write hit and a read back of the merged word
    cpu_access(1'b1, make_addr('h100, 0, 3), 32'hdeadbeef, 4'b0101, lat);
    cpu_access(1'b0, make_addr('h100, 0, 3), 32'h0, 4'h0, lat);

    // seven lines in set 1 push out the written first one
    cpu_access(1'b1, make_addr('h200, 1, 2), 32'h01234567, 4'hf, lat);
    for (int t = 1; t <= 6; t++) begin
      cpu_access(1'b0, make_addr('h200 + t, 1, t), 32'h0, 4'h0, lat);
    end
    check_value("write-backs after set 1 overflow", 1, wb_count);
    check_value("set 1 evicted line", make_addr('h200, 1, 0), wb_addr_seen);

    // with set 2 all dirty a touch of the oldest moves the victim to the next one
    for (int t = 0; t < 6; t++) begin
      cpu_access(1'b1, make_addr('h300 + t, 2, t), 32'hcafe0000 + 32'(t), 4'hf, lat);
    end
    cpu_access(1'b0, make_addr('h300, 2, 0), 32'h0, 4'h0, lat);
    cpu_access(1'b0, make_addr('h306, 2, 4), 32'h0, 4'h0, lat);
    check_value("write-backs after set 2 overflow", 2, wb_count);
    check_value("set 2 evicted line", make_addr('h301, 2, 0), wb_addr_seen);

    // random traffic under back-pressure
    bp_on = 1'b1;
    repeat (300) begin
      stim_seed = lcg_next(stim_seed);
      r         = stim_seed;
      stim_seed = lcg_next(stim_seed);
      d         = stim_seed;
      cpu_access(r[31], make_addr('h400 + int'(r[27:20]) % 10, int'(r[13:12]), int'(r[10:8])),
                 d, r[19:16], lat);
    end
    bp_on = 1'b0;

    $display("TEST PASS");
    $finish;
  end

endmodule
